// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    localparam int DATA_W     = 32;
    localparam int MEM_ADDR_W = 8;
    localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;
    localparam int REG_IDX_W  = 4;
    localparam int IMM_W      = 12;

    localparam logic [DATA_W-1:0]    RESET_VECTOR = '0;
    localparam logic [REG_IDX_W-1:0] REG_ZERO     = 4'd0;  // Always reads as zero
    localparam logic [REG_IDX_W-1:0] REG_PC       = 4'd15; // Program counter
    localparam logic [3:0]           OP_RESERVED  = 4'b0100;

    typedef enum logic [3:0] {
        OP_OR     = 4'b0000,
        OP_AND    = 4'b0001,
        OP_ADD    = 4'b0010,
        OP_MUL    = 4'b0011,
        OP_SHL    = 4'b0101,
        OP_CMP_LE = 4'b0110,
        OP_CMP_EQ = 4'b0111,
        OP_NOR    = 4'b1000,
        OP_NAND   = 4'b1001,
        OP_XOR    = 4'b1010,
        OP_SUB    = 4'b1011,
        OP_XNOR   = 4'b1100,
        OP_SHR    = 4'b1101,
        OP_CMP_GT = 4'b1110,
        OP_CMP_NE = 4'b1111
    } alu_op_e;

    // Where the result goes and what is moved
    typedef enum logic [1:0] {
        REG_FROM_RHS = 2'b00,  // Z <- rhs
        REG_FROM_MEM = 2'b01,  // Z <- [rhs]
        MEM_AT_Z     = 2'b10,  // [Z] <- rhs
        MEM_AT_RHS   = 2'b11   // [rhs] <- Z
    } deref_e;

    typedef struct packed {
        logic                 imm_type;
        deref_e               deref;
        logic [REG_IDX_W-1:0] z;
        logic [REG_IDX_W-1:0] x;
        logic [REG_IDX_W-1:0] y;
        alu_op_e              op;
        logic [IMM_W-1:0]     imm;
        logic                 illegal;
    } decoded_insn_t;

    typedef struct packed {
        logic                  valid;  // Held until ack
        logic                  we;
        logic [MEM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     wdata;
    } core_mem_req_t;

    typedef struct packed {
        logic                  valid;  // Single-cycle strobe
        logic                  we;
        logic [MEM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     wdata;
    } host_req_t;

endpackage

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [cpu_pkg::REG_IDX_W-1:0] i_x_idx,
    input  logic [cpu_pkg::REG_IDX_W-1:0] i_y_idx,
    input  logic [cpu_pkg::REG_IDX_W-1:0] i_z_idx,
    output logic [cpu_pkg::DATA_W-1:0]    o_x_val,
    output logic [cpu_pkg::DATA_W-1:0]    o_y_val,
    output logic [cpu_pkg::DATA_W-1:0]    o_z_val,
    input  logic                          i_we,
    input  logic [cpu_pkg::REG_IDX_W-1:0] i_wr_idx,
    input  logic [cpu_pkg::DATA_W-1:0]    i_wr_data,
    input  logic [cpu_pkg::DATA_W-1:0]    i_pc_next,
    output logic                          o_jump,
    output logic [cpu_pkg::DATA_W-1:0]    o_jump_target
);

    // Only the general purpose registers are stored
    logic [cpu_pkg::DATA_W-1:0] regs [1:14];

    assign o_x_val = (i_x_idx == cpu_pkg::REG_ZERO) ? '0 :
                     (i_x_idx == cpu_pkg::REG_PC)   ? i_pc_next : regs[i_x_idx];
    assign o_y_val = (i_y_idx == cpu_pkg::REG_ZERO) ? '0 :
                     (i_y_idx == cpu_pkg::REG_PC)   ? i_pc_next : regs[i_y_idx];
    assign o_z_val = (i_z_idx == cpu_pkg::REG_ZERO) ? '0 :
                     (i_z_idx == cpu_pkg::REG_PC)   ? i_pc_next : regs[i_z_idx];

    // Writing P redirects the fetch instead of storing
    assign o_jump        = i_we && (i_wr_idx == cpu_pkg::REG_PC);
    assign o_jump_target = i_wr_data;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i < int'(cpu_pkg::REG_PC); i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_wr_idx != cpu_pkg::REG_ZERO && i_wr_idx != cpu_pkg::REG_PC) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

endmodule

// ==== verilog/insn_decode.sv ====
`timescale 1ns/1ps

module insn_decode (
    input  logic [cpu_pkg::DATA_W-1:0] i_insn,
    output cpu_pkg::decoded_insn_t     o_dec
);

    logic reserved_op;

    assign reserved_op = (i_insn[15:12] == cpu_pkg::OP_RESERVED);

    always_comb begin
        o_dec.imm_type = i_insn[30];
        o_dec.deref    = cpu_pkg::deref_e'(i_insn[29:28]);
        o_dec.z        = i_insn[27:24];
        o_dec.x        = i_insn[23:20];
        o_dec.y        = i_insn[19:16];
        o_dec.op       = cpu_pkg::alu_op_e'(i_insn[15:12]);
        o_dec.imm      = i_insn[11:0];  // Sign extended in the ALU

        // Top bit set selects formats this core does not implement
        o_dec.illegal  = i_insn[31] || reserved_op;
    end

endmodule

// ==== verilog/alu_exec.sv ====
`timescale 1ns/1ps

module alu_exec (
    input  cpu_pkg::decoded_insn_t     i_dec,
    input  logic [cpu_pkg::DATA_W-1:0] i_x,
    input  logic [cpu_pkg::DATA_W-1:0] i_y,
    output logic [cpu_pkg::DATA_W-1:0] o_rhs
);

    logic        [cpu_pkg::DATA_W-1:0] imm_ext;
    logic        [cpu_pkg::DATA_W-1:0] operand;   // O
    logic        [cpu_pkg::DATA_W-1:0] addend;    // A
    logic        [cpu_pkg::DATA_W-1:0] op_result;
    logic signed [cpu_pkg::DATA_W-1:0] x_signed;
    logic signed [cpu_pkg::DATA_W-1:0] o_signed;
    logic        [4:0]                 shamt;
    logic                              cmp_le;
    logic                              cmp_eq;

    assign imm_ext = {{(cpu_pkg::DATA_W-cpu_pkg::IMM_W){i_dec.imm[cpu_pkg::IMM_W-1]}},
                      i_dec.imm};

    // Type 1 swaps the roles of Y and the immediate
    assign operand = i_dec.imm_type ? imm_ext : i_y;
    assign addend  = i_dec.imm_type ? i_y : imm_ext;

    assign x_signed = i_x;
    assign o_signed = operand;
    assign shamt    = operand[4:0];
    assign cmp_le   = (x_signed <= o_signed);
    assign cmp_eq   = (i_x == operand);

    always_comb begin
        case (i_dec.op)
            cpu_pkg::OP_OR:     op_result = i_x | operand;
            cpu_pkg::OP_AND:    op_result = i_x & operand;
            cpu_pkg::OP_ADD:    op_result = i_x + operand;
            cpu_pkg::OP_MUL:    op_result = i_x * operand;  // Low word only
            cpu_pkg::OP_SHL:    op_result = i_x << shamt;
            cpu_pkg::OP_CMP_LE: op_result = {{(cpu_pkg::DATA_W-1){1'b0}}, cmp_le};
            cpu_pkg::OP_CMP_EQ: op_result = {{(cpu_pkg::DATA_W-1){1'b0}}, cmp_eq};
            cpu_pkg::OP_NOR:    op_result = ~(i_x | operand);
            cpu_pkg::OP_NAND:   op_result = ~(i_x & operand);
            cpu_pkg::OP_XOR:    op_result = i_x ^ operand;
            cpu_pkg::OP_SUB:    op_result = i_x - operand;
            cpu_pkg::OP_XNOR:   op_result = ~(i_x ^ operand);
            cpu_pkg::OP_SHR:    op_result = i_x >> shamt;    // Logical
            cpu_pkg::OP_CMP_GT: op_result = {{(cpu_pkg::DATA_W-1){1'b0}}, !cmp_le};
            cpu_pkg::OP_CMP_NE: op_result = {{(cpu_pkg::DATA_W-1){1'b0}}, !cmp_eq};
            default:            op_result = '0;  // Reserved code, flagged by decode
        endcase
    end

    assign o_rhs = op_result + addend;

endmodule

// ==== verilog/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_run,
    output cpu_pkg::core_mem_req_t     o_mem_req,
    input  logic                       i_mem_ack,
    input  logic [cpu_pkg::DATA_W-1:0] i_mem_rdata,
    output logic                       o_halt,
    output logic                       o_retire
);

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_WRITE
    } state_e;

    state_e                     state;
    cpu_pkg::decoded_insn_t     dec;
    logic [cpu_pkg::DATA_W-1:0] pc;
    logic [cpu_pkg::DATA_W-1:0] pc_next;
    logic [cpu_pkg::DATA_W-1:0] insn_q;
    logic [cpu_pkg::DATA_W-1:0] rhs;
    logic [cpu_pkg::DATA_W-1:0] rhs_q;
    logic [cpu_pkg::DATA_W-1:0] load_q;
    logic [cpu_pkg::DATA_W-1:0] x_val;
    logic [cpu_pkg::DATA_W-1:0] y_val;
    logic [cpu_pkg::DATA_W-1:0] z_val;
    logic [cpu_pkg::DATA_W-1:0] wr_data;
    logic [cpu_pkg::DATA_W-1:0] jump_target;
    logic                       reg_we;
    logic                       jump;
    logic                       halt_q;
    logic                       is_store;

    assign pc_next  = pc + 1'b1;  // What P reads as
    assign is_store = (dec.deref == cpu_pkg::MEM_AT_Z) || (dec.deref == cpu_pkg::MEM_AT_RHS);
    assign reg_we   = (state == ST_WRITE) && !is_store;
    assign wr_data  = (dec.deref == cpu_pkg::REG_FROM_MEM) ? load_q : rhs_q;

    insn_decode u_decode (
        .i_insn (insn_q),
        .o_dec  (dec)
    );

    reg_file u_regs (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_x_idx       (dec.x),
        .i_y_idx       (dec.y),
        .i_z_idx       (dec.z),
        .o_x_val       (x_val),
        .o_y_val       (y_val),
        .o_z_val       (z_val),
        .i_we          (reg_we),
        .i_wr_idx      (dec.z),
        .i_wr_data     (wr_data),
        .i_pc_next     (pc_next),
        .o_jump        (jump),
        .o_jump_target (jump_target)
    );

    alu_exec u_alu (
        .i_dec (dec),
        .i_x   (x_val),
        .i_y   (y_val),
        .o_rhs (rhs)
    );

    // Register operands stay stable until WRITE, so Z is read live in MEM
    always_comb begin
        o_mem_req = '0;
        if (i_run && !halt_q) begin
            if (state == ST_FETCH) begin
                o_mem_req.valid = 1'b1;
                o_mem_req.addr  = pc[cpu_pkg::MEM_ADDR_W-1:0];
            end else if (state == ST_MEM) begin
                o_mem_req.valid = 1'b1;
                o_mem_req.we    = is_store;
                if (dec.deref == cpu_pkg::MEM_AT_Z) begin
                    o_mem_req.addr  = z_val[cpu_pkg::MEM_ADDR_W-1:0];
                    o_mem_req.wdata = rhs_q;
                end else begin
                    o_mem_req.addr  = rhs_q[cpu_pkg::MEM_ADDR_W-1:0];
                    o_mem_req.wdata = z_val;  // Unused for loads
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state  <= ST_FETCH;
            pc     <= cpu_pkg::RESET_VECTOR;
            halt_q <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: if (i_mem_ack) state <= ST_EXEC;
                ST_EXEC: begin
                    if (dec.illegal) begin
                        halt_q <= 1'b1;  // Sticky until reset
                        state  <= ST_FETCH;
                    end else if (dec.deref == cpu_pkg::REG_FROM_RHS) begin
                        state <= ST_WRITE;
                    end else begin
                        state <= ST_MEM;
                    end
                end
                ST_MEM: if (i_mem_ack) state <= ST_WRITE;
                ST_WRITE: begin
                    pc    <= jump ? jump_target : pc_next;
                    state <= ST_FETCH;
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // Datapath latches
    always_ff @(posedge clk) begin
        if (state == ST_FETCH && i_mem_ack) insn_q <= i_mem_rdata;
        if (state == ST_EXEC) rhs_q <= rhs;
        if (state == ST_MEM && i_mem_ack) load_q <= i_mem_rdata;
    end

    assign o_halt   = halt_q;
    assign o_retire = (state == ST_WRITE);

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                           clk,
    input  logic                           reset_n,
    input  cpu_pkg::host_req_t             i_host,
    output logic                           o_host_rvalid,
    output logic [cpu_pkg::DATA_W-1:0]     o_host_rdata,
    input  cpu_pkg::core_mem_req_t         i_core_req,
    output logic                           o_core_ack,
    output logic [cpu_pkg::DATA_W-1:0]     o_core_rdata,
    output logic                           o_ram_en,
    output logic                           o_ram_we,
    output logic [cpu_pkg::MEM_ADDR_W-1:0] o_ram_addr,
    output logic [cpu_pkg::DATA_W-1:0]     o_ram_wdata,
    input  logic [cpu_pkg::DATA_W-1:0]     i_ram_rdata
);

    logic host_grant;
    logic core_grant;
    logic host_rd_q;    // Host read in flight
    logic core_busy_q;  // Core access in flight, acked this cycle

    // Host strobe cannot wait so it always wins
    assign host_grant = i_host.valid;
    // The core still holds valid during its ack cycle
    assign core_grant = i_core_req.valid && !host_grant && !core_busy_q;

    always_comb begin
        o_ram_en    = host_grant || core_grant;
        o_ram_we    = 1'b0;
        o_ram_addr  = i_core_req.addr;
        o_ram_wdata = i_core_req.wdata;
        if (host_grant) begin
            o_ram_we    = i_host.we;
            o_ram_addr  = i_host.addr;
            o_ram_wdata = i_host.wdata;
        end else if (core_grant) begin
            o_ram_we = i_core_req.we;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            host_rd_q   <= 1'b0;
            core_busy_q <= 1'b0;
        end else begin
            host_rd_q   <= host_grant && !i_host.we;
            core_busy_q <= core_grant;
        end
    end

    // RAM output belongs to whichever side owned last cycle
    assign o_host_rvalid = host_rd_q;
    assign o_host_rdata  = i_ram_rdata;
    assign o_core_ack    = core_busy_q;
    assign o_core_rdata  = i_ram_rdata;

endmodule

// ==== verilog/word_ram.sv ====
`timescale 1ns/1ps

module word_ram (
    input  logic                           clk,
    input  logic                           i_en,
    input  logic                           i_we,
    input  logic [cpu_pkg::MEM_ADDR_W-1:0] i_addr,
    input  logic [cpu_pkg::DATA_W-1:0]     i_wdata,
    output logic [cpu_pkg::DATA_W-1:0]     o_rdata
);

    logic [cpu_pkg::DATA_W-1:0] mem [0:cpu_pkg::MEM_DEPTH-1];

    // Single port, read data one edge after the enable
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_run,
    input  cpu_pkg::host_req_t         i_host,
    output logic                       o_host_rvalid,
    output logic [cpu_pkg::DATA_W-1:0] o_host_rdata,
    output logic                       o_halt,
    output logic                       o_retire
);

    cpu_pkg::core_mem_req_t            core_req;
    logic                              core_ack;
    logic [cpu_pkg::DATA_W-1:0]        core_rdata;
    logic                              ram_en;
    logic                              ram_we;
    logic [cpu_pkg::MEM_ADDR_W-1:0]    ram_addr;
    logic [cpu_pkg::DATA_W-1:0]        ram_wdata;
    logic [cpu_pkg::DATA_W-1:0]        ram_rdata;

    cpu_core u_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_run       (i_run),
        .o_mem_req   (core_req),
        .i_mem_ack   (core_ack),
        .i_mem_rdata (core_rdata),
        .o_halt      (o_halt),
        .o_retire    (o_retire)
    );

    mem_arbiter u_arbiter (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_host        (i_host),
        .o_host_rvalid (o_host_rvalid),
        .o_host_rdata  (o_host_rdata),
        .i_core_req    (core_req),
        .o_core_ack    (core_ack),
        .o_core_rdata  (core_rdata),
        .o_ram_en      (ram_en),
        .o_ram_we      (ram_we),
        .o_ram_addr    (ram_addr),
        .o_ram_wdata   (ram_wdata),
        .i_ram_rdata   (ram_rdata)
    );

    word_ram u_ram (
        .clk     (clk),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

endmodule

// ==== verification/cpu_properties.sv ====
`timescale 1ns/1ps

module cpu_properties (
    input logic                   clk,
    input logic                   reset_n,
    input cpu_pkg::host_req_t     i_host,
    input cpu_pkg::core_mem_req_t i_core_req,
    input logic                   i_ram_we,
    input logic                   i_host_rvalid,
    input logic                   i_halt,
    input logic                   i_retire
);

    int fail_count = 0;  // Read by the testbench at the end

    // Read data comes back exactly one cycle after each host read strobe
    assert property (@(posedge clk) disable iff (!reset_n)
        (i_host.valid && !i_host.we) |=> i_host_rvalid)
    else begin
        fail_count++;
        $error("Host read strobe without read valid one cycle later");
    end

    // Halt is sticky
    assert property (@(posedge clk) disable iff (!reset_n) i_halt |=> i_halt)
    else begin
        fail_count++;
        $error("Halt fell while out of reset");
    end

    assert property (@(posedge clk) disable iff (!reset_n) i_halt |-> !i_retire)
    else begin
        fail_count++;
        $error("Instruction retired while halted");
    end

    assert property (@(posedge clk) $rose(reset_n) |->
        !i_halt && !i_retire && !i_host_rvalid && !i_core_req.valid && !i_ram_we)
    else begin
        fail_count++;
        $error("Outputs active in the first cycle after reset");
    end

endmodule

bind cpu_top cpu_properties u_props (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_host        (i_host),
    .i_core_req    (core_req),
    .i_ram_we      (ram_we),
    .i_host_rvalid (o_host_rvalid),
    .i_halt        (o_halt),
    .i_retire      (o_retire)
);

// ==== verification/tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 10;
    localparam int NUM_PROGRAMS    = 5;
    localparam int WATCHDOG_CYCLES = NUM_PROGRAMS * 300 * 10 + 1000;
    localparam int MAX_STEPS       = 300;
    localparam int QUIET_BASE      = 224;  // Words no program touches

    logic                       clk;
    logic                       reset_n;
    logic                       i_run;
    cpu_pkg::host_req_t         i_host;
    logic                       o_host_rvalid;
    logic [cpu_pkg::DATA_W-1:0] o_host_rdata;
    logic                       o_halt;
    logic                       o_retire;

    logic [31:0] model_mem [0:255];
    logic [31:0] model_regs [0:15];
    logic [31:0] prog [$];
    integer      seed;
    int          errors;
    int          checks;
    int          model_steps;   // Instructions the model retired
    int          retired = 0;   // Retire pulses seen since time zero

    cpu_top i_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_run         (i_run),
        .i_host        (i_host),
        .o_host_rvalid (o_host_rvalid),
        .o_host_rdata  (o_host_rdata),
        .o_halt        (o_halt),
        .o_retire      (o_retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (o_retire === 1'b1) retired++;
    end

    function automatic logic [31:0] fill_word(input logic [7:0] addr);
        return {addr, ~addr, addr ^ 8'h5a, addr + 8'h3c};
    endfunction

    // Operation rule, comparisons signed, shifts by five bits
    function automatic logic [31:0] apply_op(input logic [3:0] op, input logic [31:0] x,
                                             input logic [31:0] o);
        case (op)
            4'h0: return x | o;
            4'h1: return x & o;
            4'h2: return x + o;
            4'h3: return x * o;
            4'h5: return x << o[4:0];
            4'h6: return ($signed(x) <= $signed(o)) ? 32'd1 : 32'd0;
            4'h7: return (x == o) ? 32'd1 : 32'd0;
            4'h8: return ~(x | o);
            4'h9: return ~(x & o);
            4'ha: return x ^ o;
            4'hb: return x - o;
            4'hc: return ~(x ^ o);
            4'hd: return x >> o[4:0];
            4'he: return ($signed(x) > $signed(o)) ? 32'd1 : 32'd0;
            4'hf: return (x != o) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] model_reg(input logic [3:0] idx, input logic [31:0] pc);
        if (idx == 4'd0) return 32'd0;
        if (idx == 4'd15) return pc + 32'd1;
        return model_regs[idx];
    endfunction

    // Runs the loaded program on the model memory until an illegal word
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] w;
        logic [31:0] imm_ext;
        logic [31:0] zv;
        logic [31:0] rhs;
        logic [31:0] wval;
        logic        wr;
        int          steps;
        for (int i = 0; i < 16; i++) model_regs[i] = 32'd0;
        pc = 32'd0;
        steps = 0;
        while (steps < MAX_STEPS) begin
            w = model_mem[pc[7:0]];
            if (w[31] || w[15:12] == 4'b0100) break;
            imm_ext = {{20{w[11]}}, w[11:0]};
            zv = model_reg(w[27:24], pc);
            if (w[30]) begin
                rhs = apply_op(w[15:12], model_reg(w[23:20], pc), imm_ext)
                      + model_reg(w[19:16], pc);
            end else begin
                rhs = apply_op(w[15:12], model_reg(w[23:20], pc), model_reg(w[19:16], pc))
                      + imm_ext;
            end
            next_pc = pc + 32'd1;
            wr = 1'b0;
            wval = rhs;
            case (w[29:28])
                2'b00: wr = 1'b1;
                2'b01: begin
                    wr = 1'b1;
                    wval = model_mem[rhs[7:0]];
                end
                2'b10: model_mem[zv[7:0]] = rhs;
                default: model_mem[rhs[7:0]] = zv;
            endcase
            if (wr && w[27:24] == 4'd15) next_pc = wval;  // Jump
            else if (wr && w[27:24] != 4'd0) model_regs[w[27:24]] = wval;
            pc = next_pc;
            steps++;
        end
        model_steps = steps;
    endtask

    task automatic push_insn(input int t, input logic [1:0] d, input int z, input int x,
                             input int y, input int op, input int imm);
        prog.push_back({1'b0, t[0], d, z[3:0], x[3:0], y[3:0], op[3:0], imm[11:0]});
    endtask

    task automatic build_program(input int kind);
        logic [31:0] rnd;
        int          slot;
        slot = 0;
        prog.delete();
        case (kind)
            0: begin  // Every opcode with both types
                push_insn(0, cpu_pkg::REG_FROM_MEM, 1, 0, 0, 0, 100);
                push_insn(0, cpu_pkg::REG_FROM_MEM, 2, 0, 0, 0, 101);
                for (int op = 0; op < 16; op++) begin
                    if (op == 4) continue;
                    for (int t = 0; t < 2; t++) begin
                        rnd = $random(seed);
                        push_insn(0, cpu_pkg::REG_FROM_RHS, 3, 0, 0, 0, 128 + slot);
                        push_insn(t, cpu_pkg::MEM_AT_Z, 3, 1, 2, op, int'(rnd[11:0]));
                        slot++;
                    end
                end
            end
            1: begin  // Deref modes and writes to register 0
                push_insn(0, cpu_pkg::REG_FROM_MEM, 1, 0, 0, 0, 100);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 1, 0, 0, 0, 110);
                push_insn(0, cpu_pkg::REG_FROM_RHS, 0, 0, 0, 0, 'h123);
                push_insn(0, cpu_pkg::REG_FROM_MEM, 0, 0, 0, 0, 100);
                push_insn(0, cpu_pkg::REG_FROM_RHS, 4, 0, 0, 0, 111);
                push_insn(0, cpu_pkg::MEM_AT_Z, 4, 0, 0, 0, 0);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 0, 0, 0, 0, 112);
                push_insn(0, cpu_pkg::REG_FROM_MEM, 5, 0, 0, 0, 110);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 5, 0, 0, 0, 113);
            end
            2: begin  // Jumps through register 15
                push_insn(0, cpu_pkg::REG_FROM_MEM, 1, 0, 0, 0, 100);
                push_insn(0, cpu_pkg::REG_FROM_RHS, 15, 0, 0, 0, 5);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 1, 0, 0, 0, 120);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 1, 0, 0, 0, 121);
                prog.push_back(32'h8000_0000);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 1, 0, 0, 0, 122);  // Target
                push_insn(0, cpu_pkg::REG_FROM_RHS, 2, 15, 0, 0, 0);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 2, 0, 0, 0, 123);
                push_insn(0, cpu_pkg::REG_FROM_MEM, 15, 0, 0, 0, 102);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 1, 0, 0, 0, 124);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 1, 0, 0, 0, 125);
            end
            default: begin  // Reserved opcode halts before the last store
                push_insn(0, cpu_pkg::REG_FROM_MEM, 1, 0, 0, 0, 100);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 1, 0, 0, 0, 126);
                push_insn(0, cpu_pkg::REG_FROM_RHS, 1, 0, 0, 4, 0);
                push_insn(0, cpu_pkg::MEM_AT_RHS, 1, 0, 0, 0, 127);
            end
        endcase
        prog.push_back(32'h8000_0000);
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;
        @(posedge clk);  // Host stays idle in the first cycle out of reset
        #DRIVE_DELAY;
    endtask

    // Host tasks start and end a drive delay after a rising edge
    task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
        i_host = '{valid: 1'b1, we: 1'b1, addr: addr, wdata: data};
        model_mem[addr] = data;
        @(posedge clk);
        #DRIVE_DELAY;
        i_host = '0;
    endtask

    task automatic host_read_check(input logic [7:0] addr, input logic [31:0] expected);
        i_host = '{valid: 1'b1, we: 1'b0, addr: addr, wdata: 32'd0};
        @(posedge clk);
        #DRIVE_DELAY;
        i_host = '0;
        checks++;
        assert (o_host_rvalid === 1'b1) else begin
            errors++;
            $display("ERROR @%0t: no read valid one cycle after strobe to word %0d", $time, addr);
        end
        assert (o_host_rdata === expected) else begin
            errors++;
            $display("ERROR @%0t: word %0d read %h, expected %h", $time, addr, o_host_rdata,
                     expected);
        end
    endtask

    task automatic run_program(input int kind, input bit busy_host);
        logic [31:0] rnd;
        logic [7:0]  addr;
        int          retire_base;
        apply_reset();
        for (int a = 0; a < 256; a++) host_write(a[7:0], fill_word(a[7:0]));
        host_write(8'd100, $random(seed));  // Random X and Y operands
        host_write(8'd101, $random(seed));
        host_write(8'd102, 32'd10);         // Jump target loaded from memory
        build_program(kind);
        foreach (prog[i]) host_write(i[7:0], prog[i]);
        run_model();
        retire_base = retired;
        i_run = 1'b1;
        while (o_halt !== 1'b1) begin
            rnd = $random(seed);
            if (busy_host && rnd[0]) begin
                addr = 8'(QUIET_BASE) + {3'b000, rnd[12:8]};
                host_read_check(addr, fill_word(addr));
            end else begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        i_run = 1'b0;
        checks++;
        assert (retired - retire_base == model_steps) else begin
            errors++;
            $display("ERROR @%0t: %0d instructions retired, expected %0d", $time,
                     retired - retire_base, model_steps);
        end
        for (int a = 0; a < 256; a++) host_read_check(a[7:0], model_mem[a]);
    endtask

    task automatic print_counts();
        $display("Checks: %0d  errors: %0d  property failures: %0d", checks, errors,
                 i_dut.u_props.fail_count);
    endtask

    initial begin
        seed = 32'h9f03_77dc;
        errors = 0;
        checks = 0;
        reset_n = 1'b0;
        i_run = 1'b0;
        i_host = '0;
        run_program(0, 1'b0);
        run_program(1, 1'b0);
        run_program(2, 1'b0);
        run_program(3, 1'b0);
        run_program(0, 1'b1);  // Host reads collide with the core
        print_counts();
        if (errors == 0 && i_dut.u_props.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the core did not halt within %0d cycles", WATCHDOG_CYCLES);
        print_counts();
        $display("sim failed");
        $finish;
    end

endmodule

// ==== all.f ====
verilog/cpu_pkg.sv
verilog/reg_file.sv
verilog/insn_decode.sv
verilog/alu_exec.sv
verilog/cpu_core.sv
verilog/mem_arbiter.sv
verilog/word_ram.sv
verilog/cpu_top.sv
verification/cpu_properties.sv
verification/tb_cpu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu_top -Mdir "$BUILD_DIR" -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

# Raised error limit keeps the run going after an assertion error
"./$BUILD_DIR/Vtb_cpu_top" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG_FILE"; then
    echo "Testbench reported errors, see $LOG_FILE"
    exit 1
fi

echo "Testbench run clean"
exit 0
